// ==== build.f ====
design/alu_pkg.sv
design/alu_slice_if.sv
design/full_adder.sv
design/carry_gen.sv
design/alu_slice.sv
design/alu_top.sv
sim/alu_tb.sv

// ==== sim/alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_tb
    import alu_pkg::*;
();

    typedef struct {
        alu_data_t res;
        logic      carry;
        logic      equal;
        int        due;   // sample cycle at which res_valid must be high
    } expect_t;

    localparam int num_ops    = 2000;
    localparam int max_cycles = 20000; // bound on the stimulus loop
    localparam int drain_wait = 10;    // cycles allowed for the last results

    logic      clk;
    logic      arst_n;
    logic      op_valid;
    alu_data_t op_a;
    alu_data_t op_b;
    alu_cmd_t  op_cmd;
    logic      res_valid;
    alu_data_t res;
    logic      carry_out;
    logic      equal;

    expect_t   pending[$]; // expected results in issue order
    int        cycle;      // counts falling edges once reset is over
    int        issued;
    int        wait_cnt;
    alu_cmd_t  cmd_list[8];

    alu_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_cmd    (op_cmd),
        .res_valid (res_valid),
        .res       (res),
        .carry_out (carry_out),
        .equal     (equal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input alu_data_t got, input alu_data_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // reference behavior of every command, straight from integer arithmetic
    function automatic expect_t model_op(input alu_cmd_t cmd, input alu_data_t a,
                                         input alu_data_t b);
        expect_t             e;
        logic [data_width:0] wide;
        e.res   = '0;
        e.carry = 1'b0;
        e.equal = 1'b0;
        e.due   = 0;
        case (cmd)
            ADD: begin
                wide    = {1'b0, a} + {1'b0, b};
                e.res   = wide[data_width-1:0];
                e.carry = wide[data_width];
            end
            SUB: begin
                e.res   = a - b;
                e.carry = (a >= b); // no borrow
            end
            COMP: begin
                e.res   = a - b - 1'b1;
                e.carry = (a > b);
                e.equal = (a == b);
            end
            XOR:     e.res = a ^ b;
            XNOR:    e.res = ~(a ^ b);
            AND:     e.res = a & b;
            OR:      e.res = a | b;
            RSHFT:   e.res = b >> 1; // zero enters at the top
            default: e.res = 'x;
        endcase
        return e;
    endfunction

    task automatic check_reset_values();
        check_flag(res_valid, 1'b0, "res_valid after reset");
        check_data(res, '0, "res after reset");
        check_flag(carry_out, 1'b0, "carry_out after reset");
        check_flag(equal, 1'b0, "equal after reset");
    endtask

    // called on every falling edge, when the registered outputs are settled
    task automatic check_outputs();
        expect_t e;
        if (res_valid === 1'b1) begin
            if (pending.size() == 0) begin
                fail_run("res_valid went high with no operation outstanding");
            end else begin
                e = pending.pop_front();
                if (e.due != cycle) begin
                    fail_run("res_valid came on the wrong cycle");
                end else begin
                    check_data(res, e.res, "res");
                    check_flag(carry_out, e.carry, "carry_out");
                    check_flag(equal, e.equal, "equal");
                end
            end
        end else if (res_valid !== 1'b0) begin
            fail_run("res_valid is unknown");
        end else if (pending.size() > 0 && pending[0].due < cycle) begin
            fail_run("res_valid missing for an issued operation");
        end
    endtask

    task automatic drive_random();
        alu_cmd_t  cmd;
        alu_data_t a;
        alu_data_t b;
        expect_t   e;
        cmd = cmd_list[$urandom_range(7)];
        a   = alu_data_t'($urandom);
        b   = alu_data_t'($urandom);
        if ($urandom_range(15) == 0) a = '1; // corner operands now and then
        if ($urandom_range(15) == 0) b = '0;
        if (cmd == COMP && $urandom_range(3) == 0) b = a; // equal operands for the flag
        op_valid = ($urandom_range(3) != 0);
        op_a     = a;
        op_b     = b;
        op_cmd   = cmd;
        if (op_valid) begin
            e     = model_op(cmd, a, b);
            e.due = cycle + 2; // captured on the next rise, registered one cycle later
            pending.push_back(e);
            issued++;
        end
    endtask

    initial begin
        void'($urandom(32'hac00_3a0d));
        cmd_list = '{ADD, SUB, XOR, XNOR, COMP, AND, OR, RSHFT};
        arst_n   = 1'b0;
        op_valid = 1'b0;
        op_a     = '0;
        op_b     = '0;
        op_cmd   = ADD;
        cycle    = 0;
        issued   = 0;
        wait_cnt = 0;

        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_values();
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_reset_values(); // one idle cycle out of reset

        while (issued < num_ops) begin
            @(negedge clk);
            cycle++;
            if (cycle > max_cycles) begin
                fail_run("stimulus loop ran out of cycles");
            end else begin
                check_outputs();
                drive_random();
            end
        end

        // let the last results come out, then watch for stray strobes
        while (pending.size() > 0 && wait_cnt < drain_wait) begin
            @(negedge clk);
            cycle++;
            wait_cnt++;
            op_valid = 1'b0;
            check_outputs();
        end
        repeat (2) begin
            @(negedge clk);
            cycle++;
            op_valid = 1'b0;
            check_outputs();
        end

        if (pending.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run("results still outstanding when the drain timed out");
        end
    end

endmodule

`default_nettype wire

// ==== design/alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_top
    import alu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      op_valid,
    input  alu_data_t op_a,
    input  alu_data_t op_b,
    input  alu_cmd_t  op_cmd,
    output logic      res_valid,
    output alu_data_t res,
    output logic      carry_out,
    output logic      equal
);

    logic      valid_q;  // an operation sits in the capture register
    alu_data_t a_q;
    alu_data_t b_q;
    alu_ctrl_t ctrl_q;   // captured command, read through both union views

    alu_data_t              cascade_res;  // combinational result of all slices
    logic [num_slices:0]    ripple_chain; // entry k is the carry into slice k
    logic [num_slices:0]    shift_chain;  // entry k is b bit 0 of slice k
    logic                   is_arith;     // ADD, SUB or COMP
    logic                   is_shift;     // RSHFT
    logic                   is_equal;

    // input capture stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            a_q        <= op_a;
            b_q        <= op_b;
            ctrl_q.cmd <= op_cmd;
        end
    end

    assign is_arith = !ctrl_q.bits.carry_disable && (ctrl_q.bits.cmd == sel_sum);
    assign is_shift = (ctrl_q.bits.cmd == sel_shift);

    // slice 0 gets the command carry on arithmetic, the top slice gets it on a shift
    assign ripple_chain[0]          = ctrl_q.bits.carry_in;
    assign shift_chain[num_slices]  = ctrl_q.bits.carry_in;

    for (genvar k = 0; k < num_slices; k++) begin : g_slice
        alu_slice_if u_bus ();

        alu_slice u_slice (
            .bus (u_bus.slice)
        );

        assign u_bus.d1 = a_q[k*slice_width +: slice_width];
        assign u_bus.d2 = b_q[k*slice_width +: slice_width];

        // carry_in of the struct stays clear, the slice reads its own carry_in
        assign u_bus.ctrl_bits = '{
            carry_in:      1'b0,
            b_inv:         ctrl_q.bits.b_inv,
            carry_disable: ctrl_q.bits.carry_disable,
            cmd:           ctrl_q.bits.cmd
        };

        // arithmetic ripples upward, the shift pulls b bits downward
        assign u_bus.carry_in = is_shift ? shift_chain[k+1]
                              : is_arith ? ripple_chain[k]
                              : 1'b0;

        assign ripple_chain[k+1] = u_bus.carry_out;
        assign shift_chain[k]    = u_bus.d2_lsb;
        assign cascade_res[k*slice_width +: slice_width] = u_bus.res;
    end

    // all ones after a-b-1 means the operands were equal
    assign is_equal = (ctrl_q.cmd == COMP) && (&cascade_res);

    // output register stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            res       <= '0;
            carry_out <= 1'b0;
            equal     <= 1'b0;
        end else begin
            res_valid <= valid_q;
            if (valid_q) begin
                res       <= cascade_res;
                carry_out <= ripple_chain[num_slices]; // zero for logic and shift
                equal     <= is_equal;
            end
        end
    end

    // every accepted command produces exactly one result strobe, two edges later
    a_valid_follows : assert property (
        @(posedge clk) disable iff (!arst_n)
        op_valid |=> ##1 res_valid
    ) else $error("res_valid missing after op_valid");

    a_valid_origin : assert property (
        @(posedge clk) disable iff (!arst_n)
        res_valid |-> $past(op_valid, 2)
    ) else $error("res_valid without a matching op_valid");

    // the equal flag of a result belongs to a COMP command issued two edges before
    a_equal_comp : assert property (
        @(posedge clk) disable iff (!arst_n)
        (res_valid && equal) |-> ($past(op_cmd, 2) == COMP)
    ) else $error("equal raised for a command other than COMP");

endmodule

`default_nettype wire

// ==== design/alu_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_slice
    import alu_pkg::*;
(
    alu_slice_if.slice bus
);

    slice_data_t            gen;      // per-bit generate
    slice_data_t            prop;     // per-bit propagate
    slice_data_t            d2_inv;   // b after the optional inversion
    slice_data_t            carry;    // carry into each bit position
    logic [slice_width:0]   shift_in; // bit i+1 feeds the shift input of bit i

    // bit 0 takes the slice carry, the rest come from the lookahead unit
    assign carry[0] = bus.carry_in;

    // on a right shift the slice carry input is the bit entering from above
    assign shift_in = {bus.carry_in, d2_inv};

    carry_gen u_carry_gen (
        .carry_in (bus.carry_in),
        .gen      (gen),
        .prop     (prop),
        .carry    (carry[slice_width-1:1]),
        .gen_out  (bus.carry_out)
    );

    for (genvar i = 0; i < slice_width; i++) begin : g_bit
        full_adder u_fa (
            .data1                (bus.d1[i]),
            .data2                (bus.d2[i]),
            .carry_in             (carry[i]),
            .direct_in            (shift_in[i+1]),
            .carry_disable        (bus.ctrl_bits.carry_disable),
            .b_inv                (bus.ctrl_bits.b_inv),
            .sel                  (bus.ctrl_bits.cmd),
            .res                  (bus.res[i]),
            .gen                  (gen[i]),
            .propagate            (prop[i]),
            .d2_possible_inverted (d2_inv[i])
        );
    end

    // RSHFT never inverts b, so the raw bit is what the lower slice needs
    assign bus.d2_lsb = bus.d2[0];

endmodule

`default_nettype wire

// ==== design/carry_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module carry_gen
    import alu_pkg::*;
(
    input  logic                   carry_in,
    input  logic [slice_width-1:0] gen,
    input  logic [slice_width-1:0] prop,
    output logic [slice_width-2:0] carry,  // carries into bits 1 to 3
    output logic                   gen_out // carry out of bit 3
);

    logic ripple_carry; // bit-serial carry used only to check the lookahead terms

    // two-level lookahead, every carry straight from g, p and carry_in
    assign carry[0] = gen[0] | (prop[0] & carry_in);
    assign carry[1] = gen[1] | (prop[1] & gen[0]) | (prop[1] & prop[0] & carry_in);
    assign carry[2] = gen[2] | (prop[2] & gen[1]) | (prop[2] & prop[1] & gen[0])
                    | (prop[2] & prop[1] & prop[0] & carry_in);
    assign gen_out  = gen[3] | (prop[3] & gen[2]) | (prop[3] & prop[2] & gen[1])
                    | (prop[3] & prop[2] & prop[1] & gen[0])
                    | (&prop & carry_in);

    always_comb begin
        ripple_carry = carry_in;
        for (int i = 0; i < slice_width; i++) begin
            ripple_carry = gen[i] | (prop[i] & ripple_carry);
        end
        if (!$isunknown({carry_in, gen, prop})) begin
            a_group_carry : assert #0 (gen_out == ripple_carry)
                else $error("lookahead group carry %b differs from ripple %b", gen_out,
                            ripple_carry);
        end
    end

endmodule

`default_nettype wire

// ==== design/full_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module full_adder
    import alu_pkg::*;
(
    input  logic       data1,
    input  logic       data2,
    input  logic       carry_in,
    input  logic       direct_in,            // b bit of the next higher position
    input  logic       carry_disable,
    input  logic       b_inv,
    input  adder_sel_t sel,
    output logic       res,
    output logic       gen,
    output logic       propagate,
    output logic       d2_possible_inverted  // b after the optional inversion
);

    logic half_sum; // a xor b, before the carry is added
    logic carry_eff; // carry that actually reaches the sum

    assign d2_possible_inverted = data2 ^ b_inv;
    assign half_sum             = data1 ^ d2_possible_inverted;
    assign carry_eff            = carry_in & ~carry_disable;

    // with carries disabled the cell reports no generate or propagate, so the
    // lookahead group carry is zero for every logic or shift command
    assign gen       = data1 & d2_possible_inverted & ~carry_disable;
    assign propagate = half_sum & ~carry_disable;

    always_comb begin
        case (sel)
            sel_sum:   res = half_sum ^ carry_eff;             // sum, or plain XOR
            sel_and:   res = data1 & d2_possible_inverted;
            sel_or:    res = data1 | d2_possible_inverted;
            sel_shift: res = direct_in;                        // bit moves one place down
            default:   res = half_sum ^ carry_eff;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/alu_slice_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface alu_slice_if
    import alu_pkg::*;
();

    slice_data_t    d1;        // first operand bits of this slice
    slice_data_t    d2;        // second operand bits of this slice
    alu_ctrl_bits_t ctrl_bits; // decoded command, carry_in field left clear
    logic           carry_in;  // ripple carry or shift-in bit, chosen by the cascade
    slice_data_t    res;       // slice result
    logic           carry_out; // group carry of the slice
    logic           d2_lsb;    // raw b bit 0, shifted into the slice below

    modport cascade (
        output d1, d2, ctrl_bits, carry_in,
        input  res, carry_out, d2_lsb
    );

    modport slice (
        input  d1, d2, ctrl_bits, carry_in,
        output res, carry_out, d2_lsb
    );

endinterface

`default_nettype wire

// ==== design/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int slice_width = 4;                        // bits handled by one lookahead slice
    localparam int num_slices  = 4;                        // slices in the cascade
    localparam int data_width  = slice_width * num_slices; // full operand width

    typedef logic [slice_width-1:0] slice_data_t; // one slice worth of operand or result
    typedef logic [data_width-1:0]  alu_data_t;   // full-width operand or result

    // Select of the output mux inside each full adder cell.
    typedef enum logic [1:0] {
        sel_sum   = 2'b00, // adder sum, or XOR when the carry is disabled
        sel_and   = 2'b01,
        sel_or    = 2'b10,
        sel_shift = 2'b11  // pass the neighbour's b bit for the right shift
    } adder_sel_t;

    // Top-level command codes. They are laid out so that the bits read
    // directly as alu_ctrl_bits_t below.
    typedef enum logic [4:0] {
        ADD   = 5'b00000, // a plus b, also shifts left when a equals b
        SUB   = 5'b11000, // carry set means no borrow, so a >= b
        XOR   = 5'b00100,
        XNOR  = 5'b01100, // NOT b when a is zero
        COMP  = 5'b01000, // a-b-1, carry means a > b, all ones means a == b
        AND   = 5'b00101,
        OR    = 5'b00110,
        RSHFT = 5'b00111  // logical right shift of b by one, a unused
    } alu_cmd_t;

    // Decoded view of a command as seen by the slices.
    typedef struct packed {
        logic       carry_in;      // carry into the least significant slice
        logic       b_inv;         // invert the second operand
        logic       carry_disable; // kill carries, turns the sum into XOR
        adder_sel_t cmd;           // output mux select of every cell
    } alu_ctrl_bits_t;

    // Same five bits, either as a command or as control fields.
    typedef union packed {
        alu_cmd_t       cmd;
        alu_ctrl_bits_t bits;
    } alu_ctrl_t;

endpackage

`default_nettype wire
